// File: common/rv_isa_pkg.sv
// rv32i instruction set definitions
package rv_isa_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [6:0]      opcode_t;
  typedef logic [2:0]      funct3_t;
  typedef logic [6:0]      funct7_t;

  // base opcodes
  localparam opcode_t op_lui     = 7'b01_101_11;
  localparam opcode_t op_auipc   = 7'b00_101_11;
  localparam opcode_t op_jal     = 7'b11_011_11;
  localparam opcode_t op_jalr    = 7'b11_001_11;
  localparam opcode_t op_branch  = 7'b11_000_11;
  localparam opcode_t op_load    = 7'b00_000_11;
  localparam opcode_t op_store   = 7'b01_000_11;
  localparam opcode_t op_reg_imm = 7'b00_100_11;
  localparam opcode_t op_reg_reg = 7'b01_100_11;
  localparam opcode_t op_environ = 7'b11_100_11;

  // selects sub and sra/srai
  localparam funct7_t funct7_alt = 7'b0100000;

  localparam funct3_t funct3_lw = 3'b010;
  localparam funct3_t funct3_sw = 3'b010;

  localparam funct3_t funct3_beq  = 3'b000;
  localparam funct3_t funct3_bne  = 3'b001;
  localparam funct3_t funct3_blt  = 3'b100;
  localparam funct3_t funct3_bge  = 3'b101;
  localparam funct3_t funct3_bltu = 3'b110;
  localparam funct3_t funct3_bgeu = 3'b111;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

endpackage

// File: common/core_cfg_pkg.sv
// core and memory configuration
package core_cfg_pkg;

  localparam int mem_words  = 1024;
  localparam int mem_addr_w = 10;

  localparam logic [31:0] reset_pc = 32'h0000_0000;

  // word index into the unified memory
  typedef logic [mem_addr_w-1:0] mem_addr_t;

  typedef enum logic {
    run,
    halted
  } core_state_t;

endpackage

// File: rtl/core/rv_decoder.sv
// rv32i instruction decoder
`timescale 1ns/1ps

module rv_decoder (
  input  rv_isa_pkg::word_t     insn,
  output rv_isa_pkg::reg_addr_t rs1,
  output rv_isa_pkg::reg_addr_t rs2,
  output rv_isa_pkg::reg_addr_t rd,
  output rv_isa_pkg::word_t     imm,
  output rv_isa_pkg::alu_op_t   alu_op,
  output logic                  use_imm,
  output logic                  reg_we,
  output logic                  is_load,
  output logic                  is_store,
  output logic                  is_branch,
  output logic                  is_jal,
  output logic                  is_jalr,
  output logic                  is_lui,
  output logic                  is_auipc,
  output logic                  is_ecall
);

  rv_isa_pkg::opcode_t opcode;
  rv_isa_pkg::funct3_t funct3;
  rv_isa_pkg::funct7_t funct7;
  rv_isa_pkg::alu_op_t alu_fn;
  logic                is_rr;
  logic                alt;
  logic                plain;
  logic                alu_legal;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];
  assign rd     = insn[11:7];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];

  assign is_rr = opcode == rv_isa_pkg::op_reg_reg;
  assign alt   = funct7 == rv_isa_pkg::funct7_alt;
  // immediate forms ignore funct7, register forms need it zero
  assign plain = !is_rr || funct7 == '0;

  always_comb begin
    case (opcode)
      rv_isa_pkg::op_store:
        imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
      rv_isa_pkg::op_branch:
        imm = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
      rv_isa_pkg::op_jal:
        imm = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
      rv_isa_pkg::op_lui, rv_isa_pkg::op_auipc:
        imm = {insn[31:12], 12'b0};
      default:
        imm = {{20{insn[31]}}, insn[31:20]};
    endcase
  end

  // alu function for both op and op-imm
  always_comb begin
    alu_fn    = rv_isa_pkg::alu_add;
    alu_legal = plain;
    case (funct3)
      3'b000: begin
        alu_fn    = (is_rr && alt) ? rv_isa_pkg::alu_sub : rv_isa_pkg::alu_add;
        alu_legal = plain || (is_rr && alt);
      end
      3'b001: begin
        alu_fn    = rv_isa_pkg::alu_sll;
        alu_legal = funct7 == '0;
      end
      3'b010: alu_fn = rv_isa_pkg::alu_slt;
      3'b011: alu_fn = rv_isa_pkg::alu_sltu;
      3'b100: alu_fn = rv_isa_pkg::alu_xor;
      3'b101: begin
        alu_fn    = alt ? rv_isa_pkg::alu_sra : rv_isa_pkg::alu_srl;
        alu_legal = funct7 == '0 || alt;
      end
      3'b110: alu_fn = rv_isa_pkg::alu_or;
      default: alu_fn = rv_isa_pkg::alu_and;
    endcase
  end

  always_comb begin
    alu_op    = rv_isa_pkg::alu_add;
    use_imm   = 1'b0;
    reg_we    = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    is_lui    = 1'b0;
    is_auipc  = 1'b0;
    is_ecall  = 1'b0;
    case (opcode)
      rv_isa_pkg::op_lui: begin
        is_lui = 1'b1;
        reg_we = 1'b1;
      end
      rv_isa_pkg::op_auipc: begin
        is_auipc = 1'b1;
        reg_we   = 1'b1;
      end
      rv_isa_pkg::op_jal: begin
        is_jal = 1'b1;
        reg_we = 1'b1;
      end
      rv_isa_pkg::op_jalr: begin
        // target comes out of the alu as rs1 + imm
        is_jalr = funct3 == 3'b000;
        reg_we  = funct3 == 3'b000;
        use_imm = funct3 == 3'b000;
      end
      rv_isa_pkg::op_branch: begin
        is_branch = funct3 != 3'b010 && funct3 != 3'b011;
      end
      rv_isa_pkg::op_load: begin
        is_load = funct3 == rv_isa_pkg::funct3_lw;
        reg_we  = funct3 == rv_isa_pkg::funct3_lw;
        use_imm = funct3 == rv_isa_pkg::funct3_lw;
      end
      rv_isa_pkg::op_store: begin
        is_store = funct3 == rv_isa_pkg::funct3_sw;
        use_imm  = funct3 == rv_isa_pkg::funct3_sw;
      end
      rv_isa_pkg::op_reg_imm, rv_isa_pkg::op_reg_reg: begin
        if (alu_legal) begin
          alu_op  = alu_fn;
          use_imm = !is_rr;
          reg_we  = 1'b1;
        end
      end
      rv_isa_pkg::op_environ: begin
        is_ecall = insn[31:7] == '0;
      end
      default: begin
      end
    endcase
  end

endmodule

// File: rtl/core/rv_alu.sv
// integer alu
`timescale 1ns/1ps

module rv_alu (
  input  rv_isa_pkg::word_t   a,
  input  rv_isa_pkg::word_t   b,
  input  rv_isa_pkg::alu_op_t op,
  output rv_isa_pkg::word_t   result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // only the low five bits shift
  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      rv_isa_pkg::alu_add:  result = a + b;
      rv_isa_pkg::alu_sub:  result = a - b;
      rv_isa_pkg::alu_sll:  result = a << shamt;
      rv_isa_pkg::alu_slt:  result = {{(rv_isa_pkg::xlen-1){1'b0}}, lt_signed};
      rv_isa_pkg::alu_sltu: result = {{(rv_isa_pkg::xlen-1){1'b0}}, lt_unsigned};
      rv_isa_pkg::alu_xor:  result = a ^ b;
      rv_isa_pkg::alu_srl:  result = a >> shamt;
      rv_isa_pkg::alu_sra:  result = $signed(a) >>> shamt;
      rv_isa_pkg::alu_or:   result = a | b;
      default:              result = a & b;
    endcase
  end

endmodule

// File: rtl/core/rv_regfile.sv
// integer register file
`timescale 1ns/1ps

module rv_regfile (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_isa_pkg::reg_addr_t rs1,
  input  rv_isa_pkg::reg_addr_t rs2,
  input  rv_isa_pkg::reg_addr_t rd,
  input  logic                  we,
  input  rv_isa_pkg::word_t     wdata,
  output rv_isa_pkg::word_t     rs1_data,
  output rv_isa_pkg::word_t     rs2_data
);

  rv_isa_pkg::word_t regs [2**$bits(rv_isa_pkg::reg_addr_t)];

  // x0 never written, reads back zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**$bits(rv_isa_pkg::reg_addr_t); i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

endmodule

// File: rtl/core/rv_core.sv
// single-cycle rv32i core
`timescale 1ns/1ps

module rv_core (
  input  logic                    clk,
  input  logic                    rst,
  input  rv_isa_pkg::word_t       insn,
  input  rv_isa_pkg::word_t       dmem_rdata,
  output rv_isa_pkg::word_t       pc,
  output core_cfg_pkg::mem_addr_t dmem_addr,
  output rv_isa_pkg::word_t       dmem_wdata,
  output logic                    dmem_we,
  output logic                    halt,
  output logic                    retire_valid,
  output rv_isa_pkg::word_t       retire_pc,
  output logic                    retire_we,
  output rv_isa_pkg::reg_addr_t   retire_rd,
  output rv_isa_pkg::word_t       retire_wdata
);

  core_cfg_pkg::core_state_t state;
  rv_isa_pkg::reg_addr_t     rs1, rs2, rd;
  rv_isa_pkg::word_t         imm, rs1_data, rs2_data, alu_b, alu_result;
  rv_isa_pkg::word_t         pc_plus4, pc_rel, next_pc, wb_data;
  rv_isa_pkg::alu_op_t       alu_op;
  rv_isa_pkg::funct3_t       funct3;
  logic use_imm, reg_we, is_load, is_store, is_branch;
  logic is_jal, is_jalr, is_lui, is_auipc, is_ecall;
  logic active, taken, wb_en;

  rv_decoder u_decoder (
    .insn(insn), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .alu_op(alu_op),
    .use_imm(use_imm), .reg_we(reg_we), .is_load(is_load), .is_store(is_store),
    .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr), .is_lui(is_lui),
    .is_auipc(is_auipc), .is_ecall(is_ecall)
  );

  rv_regfile u_regfile (
    .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd), .we(wb_en),
    .wdata(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  assign alu_b = use_imm ? imm : rs2_data;

  rv_alu u_alu (.a(rs1_data), .b(alu_b), .op(alu_op), .result(alu_result));

  // nothing retires or writes while held in reset
  assign active   = state == core_cfg_pkg::run && !rst;
  assign halt     = state == core_cfg_pkg::halted;
  assign funct3   = insn[14:12];
  assign pc_plus4 = pc + 32'd4;
  assign pc_rel   = pc + imm;

  always_comb begin
    case (funct3)
      rv_isa_pkg::funct3_beq:  taken = rs1_data == rs2_data;
      rv_isa_pkg::funct3_bne:  taken = rs1_data != rs2_data;
      rv_isa_pkg::funct3_blt:  taken = $signed(rs1_data) < $signed(rs2_data);
      rv_isa_pkg::funct3_bge:  taken = $signed(rs1_data) >= $signed(rs2_data);
      rv_isa_pkg::funct3_bltu: taken = rs1_data < rs2_data;
      rv_isa_pkg::funct3_bgeu: taken = rs1_data >= rs2_data;
      default:                 taken = 1'b0;
    endcase
  end

  always_comb begin
    if (is_jalr) begin
      next_pc = {alu_result[31:1], 1'b0};
    end else if (is_jal || (is_branch && taken)) begin
      next_pc = pc_rel;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_comb begin
    if (is_load) begin
      wb_data = dmem_rdata;
    end else if (is_jal || is_jalr) begin
      wb_data = pc_plus4;
    end else if (is_lui) begin
      wb_data = imm;
    end else if (is_auipc) begin
      wb_data = pc_rel;
    end else begin
      wb_data = alu_result;
    end
  end

  assign wb_en      = active && reg_we;
  assign dmem_addr  = alu_result[core_cfg_pkg::mem_addr_w+1:2];
  assign dmem_wdata = rs2_data;
  assign dmem_we    = active && is_store;

  assign retire_valid = active;
  assign retire_pc    = pc;
  assign retire_we    = wb_en;
  assign retire_rd    = rd;
  assign retire_wdata = wb_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc    <= core_cfg_pkg::reset_pc;
      state <= core_cfg_pkg::run;
    end else if (state == core_cfg_pkg::run) begin
      pc <= next_pc;
      if (is_ecall) begin
        state <= core_cfg_pkg::halted;
      end
    end
  end

endmodule

// File: rtl/rv_mem.sv
// unified word memory
`timescale 1ns/1ps

module rv_mem (
  input  logic                    clk,
  input  rv_isa_pkg::word_t       pc,
  output rv_isa_pkg::word_t       insn,
  input  core_cfg_pkg::mem_addr_t dmem_addr,
  input  rv_isa_pkg::word_t       dmem_wdata,
  input  logic                    dmem_we,
  output rv_isa_pkg::word_t       dmem_rdata,
  input  logic                    load_valid,
  input  core_cfg_pkg::mem_addr_t load_addr,
  input  rv_isa_pkg::word_t       load_data
);

  rv_isa_pkg::word_t mem [core_cfg_pkg::mem_words];

  // both read ports are combinational
  assign insn       = mem[pc[core_cfg_pkg::mem_addr_w+1:2]];
  assign dmem_rdata = mem[dmem_addr];

  always_ff @(posedge clk) begin
    // program load wins over a store
    if (load_valid) begin
      mem[load_addr] <= load_data;
    end else if (dmem_we) begin
      mem[dmem_addr] <= dmem_wdata;
    end
  end

endmodule

// File: rtl/rv_top.sv
// core and memory top level
`timescale 1ns/1ps

module rv_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    load_valid,
  input  core_cfg_pkg::mem_addr_t load_addr,
  input  rv_isa_pkg::word_t       load_data,
  output logic                    halt,
  output logic                    retire_valid,
  output rv_isa_pkg::word_t       retire_pc,
  output logic                    retire_we,
  output rv_isa_pkg::reg_addr_t   retire_rd,
  output rv_isa_pkg::word_t       retire_wdata
);

  rv_isa_pkg::word_t       pc, insn, dmem_wdata, dmem_rdata;
  core_cfg_pkg::mem_addr_t dmem_addr;
  logic                    dmem_we;

  rv_core u_core (
    .clk(clk), .rst(rst), .insn(insn), .dmem_rdata(dmem_rdata), .pc(pc),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we), .halt(halt),
    .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_we(retire_we),
    .retire_rd(retire_rd), .retire_wdata(retire_wdata)
  );

  rv_mem u_mem (
    .clk(clk), .pc(pc), .insn(insn), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
    .dmem_we(dmem_we), .dmem_rdata(dmem_rdata), .load_valid(load_valid),
    .load_addr(load_addr), .load_data(load_data)
  );

endmodule

// File: dv/rv_checker.sv
// reference model and retire checker
`timescale 1ns/1ps

module rv_checker (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    load_valid,
  input  core_cfg_pkg::mem_addr_t load_addr,
  input  rv_isa_pkg::word_t       load_data,
  input  logic                    halt,
  input  logic                    retire_valid,
  input  rv_isa_pkg::word_t       retire_pc,
  input  logic                    retire_we,
  input  rv_isa_pkg::reg_addr_t   retire_rd,
  input  rv_isa_pkg::word_t       retire_wdata,
  output int                      errors
);

  rv_isa_pkg::word_t     regs [32];
  rv_isa_pkg::word_t     mem [core_cfg_pkg::mem_words];
  rv_isa_pkg::word_t     pc;
  logic                  model_halted;
  logic                  exp_we;
  rv_isa_pkg::reg_addr_t exp_rd;
  rv_isa_pkg::word_t     exp_wdata;
  int                    err_count = 0;

  assign errors = err_count;

  task automatic compare_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      $display("Mismatch %s: expected %h actual %h", name, expected, actual);
      err_count++;
    end
  endtask

  function automatic rv_isa_pkg::word_t alu_ref(logic [2:0] f3, logic alt,
                                                rv_isa_pkg::word_t a, rv_isa_pkg::word_t b);
    rv_isa_pkg::word_t r;
    case (f3)
      3'b000: r = alt ? a - b : a + b;
      3'b001: r = a << b[4:0];
      3'b010: r = {31'b0, $signed(a) < $signed(b)};
      3'b011: r = {31'b0, a < b};
      3'b100: r = a ^ b;
      3'b101: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      3'b110: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // one instruction of the reference machine
  task automatic step_model();
    rv_isa_pkg::word_t insn, a, b, imm_i, imm_s, imm_b, imm_j, imm_u, npc, addr;
    logic [2:0]        f3;
    logic              taken;
    insn  = mem[pc[11:2]];
    f3    = insn[14:12];
    a     = regs[insn[19:15]];
    b     = regs[insn[24:20]];
    imm_i = {{20{insn[31]}}, insn[31:20]};
    imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
    imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    imm_u = {insn[31:12], 12'h000};
    npc       = pc + 32'd4;
    exp_we    = 1'b1;
    exp_rd    = insn[11:7];
    exp_wdata = '0;
    case (insn[6:0])
      7'b0110111: exp_wdata = imm_u;
      7'b0010111: exp_wdata = pc + imm_u;
      7'b1101111: begin
        exp_wdata = pc + 32'd4;
        npc       = pc + imm_j;
      end
      7'b1100111: begin
        exp_wdata = pc + 32'd4;
        npc       = (a + imm_i) & ~32'h1;
      end
      7'b1100011: begin
        exp_we = 1'b0;
        case (f3)
          3'b000: taken = a == b;
          3'b001: taken = a != b;
          3'b100: taken = $signed(a) < $signed(b);
          3'b101: taken = $signed(a) >= $signed(b);
          3'b110: taken = a < b;
          default: taken = a >= b;
        endcase
        if (taken) begin
          npc = pc + imm_b;
        end
      end
      7'b0000011: begin
        addr      = a + imm_i;
        exp_wdata = mem[addr[11:2]];
      end
      7'b0100011: begin
        exp_we              = 1'b0;
        addr                = a + imm_s;
        mem[addr[11:2]]     = b;
      end
      // srai only when funct3 says shift right
      7'b0010011: exp_wdata = alu_ref(f3, insn[30] && f3 == 3'b101, a, imm_i);
      7'b0110011: exp_wdata = alu_ref(f3, insn[30], a, b);
      7'b1110011: begin
        exp_we       = 1'b0;
        model_halted = 1'b1;
      end
      default: exp_we = 1'b0;
    endcase
    if (exp_we && exp_rd != 5'd0) begin
      regs[exp_rd] = exp_wdata;
    end
    pc = npc;
  endtask

  always @(posedge clk) begin
    if (load_valid) begin
      mem[load_addr] = load_data;
    end
    if (rst) begin
      if (retire_valid !== 1'b0) begin
        $display("retire_valid high during reset at pc %h", retire_pc);
        err_count++;
      end
      regs         = '{default: '0};
      pc           = core_cfg_pkg::reset_pc;
      model_halted = 1'b0;
    end else begin
      compare_value("halt", 32'(model_halted), 32'(halt));
      if (model_halted) begin
        if (retire_valid !== 1'b0) begin
          $display("retire_valid pulsed after halt at pc %h", retire_pc);
          err_count++;
        end
      end else if (retire_valid !== 1'b1) begin
        $display("no retire while running at model pc %h", pc);
        err_count++;
      end else begin
        compare_value("retire_pc", pc, retire_pc);
        step_model();
        compare_value("retire_we", 32'(exp_we), 32'(retire_we));
        if (exp_we) begin
          compare_value("retire_rd", 32'(exp_rd), 32'(retire_rd));
          compare_value("retire_wdata", exp_wdata, retire_wdata);
        end
      end
    end
  end

endmodule

// File: dv/tb_top.sv
// random program testbench
`timescale 1ns/1ps

module tb_top;

  localparam int base_seed    = 48445;
  localparam int num_programs = 3;
  localparam int prog_words   = 256;
  localparam int data_base    = 256;
  localparam int data_words   = 128;
  // words that loads and stores aim at
  localparam int ls_words     = 16;
  localparam int reset_cycles = 5;
  localparam int halt_timeout = 2000;
  localparam int quiet_cycles = 20;

  logic                    clk = 1'b0;
  logic                    rst;
  logic                    load_valid;
  core_cfg_pkg::mem_addr_t load_addr;
  rv_isa_pkg::word_t       load_data;
  logic                    halt;
  logic                    retire_valid;
  logic                    retire_we;
  rv_isa_pkg::word_t       retire_pc;
  rv_isa_pkg::word_t       retire_wdata;
  rv_isa_pkg::reg_addr_t   retire_rd;
  int                      checker_errors;
  int                      tb_errors = 0;
  integer                  seed;
  rv_isa_pkg::word_t       image [data_base + data_words];
  logic                    is_target [prog_words];

  always #10 clk = ~clk;

  rv_top DUT (
    .clk(clk), .rst(rst), .load_valid(load_valid), .load_addr(load_addr),
    .load_data(load_data), .halt(halt), .retire_valid(retire_valid),
    .retire_pc(retire_pc), .retire_we(retire_we), .retire_rd(retire_rd),
    .retire_wdata(retire_wdata)
  );

  rv_checker u_checker (
    .clk(clk), .rst(rst), .load_valid(load_valid), .load_addr(load_addr),
    .load_data(load_data), .halt(halt), .retire_valid(retire_valid),
    .retire_pc(retire_pc), .retire_we(retire_we), .retire_rd(retire_rd),
    .retire_wdata(retire_wdata), .errors(checker_errors)
  );

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic rv_isa_pkg::word_t itype(logic [11:0] imm, logic [4:0] rs1,
                                              logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_isa_pkg::word_t stype(logic [11:0] imm, logic [4:0] rs2,
                                              logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic rv_isa_pkg::word_t btype(logic [12:0] off, logic [4:0] rs2,
                                              logic [4:0] rs1, logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic rv_isa_pkg::word_t jtype(logic [20:0] off, logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic build_program();
    int          i, k, kind, tgt;
    logic [4:0]  rd, ra, rb;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [6:0]  f7;
    for (i = 0; i < prog_words; i++) begin
      is_target[i] = 1'b0;
    end
    i = 0;
    while (i < prog_words - 1) begin
      kind = rand_below(16);
      // x31 is kept for jalr bases
      rd   = 5'(rand_below(31));
      ra   = 5'(rand_below(32));
      rb   = 5'(rand_below(32));
      f3   = 3'(rand_below(8));
      imm  = 12'(rand_below(4096));
      f7   = ((f3 == 3'b000 || f3 == 3'b101) && rand_below(2) == 1) ? 7'h20 : 7'h00;
      tgt  = i + 1 + rand_below(8);
      if (tgt > prog_words - 1) begin
        tgt = prog_words - 1;
      end
      // never split a jalr sequence with a branch landing inside it
      if (kind == 13 && (i > prog_words - 4 || is_target[i+1] || is_target[i+2])) begin
        kind = 0;
      end
      case (kind)
        0, 1, 2, 3, 4: begin
          if (f3 == 3'b001 || f3 == 3'b101) begin
            imm = {f3 == 3'b101 ? f7 : 7'h00, imm[4:0]};
          end
          image[i] = itype(imm, ra, f3, rd, 7'b0010011);
        end
        5, 6, 7, 8: image[i] = {f7, rb, ra, f3, rd, 7'b0110011};
        9: image[i] = {20'(rand_below(1 << 20)), rd, 7'b0110111};
        10: image[i] = {20'(rand_below(1 << 20)), rd, 7'b0010111};
        11: begin
          k            = rand_below(6);
          f3           = 3'(k >= 2 ? k + 2 : k);
          image[i]     = btype(13'((tgt - i) * 4), rb, ra, f3);
          is_target[tgt] = 1'b1;
        end
        12: begin
          image[i]       = jtype(21'((tgt - i) * 4), rd);
          is_target[tgt] = 1'b1;
        end
        13: begin
          tgt = i + 3 + rand_below(8);
          if (tgt > prog_words - 1) begin
            tgt = prog_words - 1;
          end
          image[i]       = {20'h00000, 5'd31, 7'b0110111};
          image[i+1]     = itype(12'(tgt * 4), 5'd31, 3'b000, 5'd31, 7'b0010011);
          image[i+2]     = itype(12'h000, 5'd31, 3'b000, rd, 7'b1100111);
          is_target[tgt] = 1'b1;
          i              = i + 2;
        end
        14: begin
          imm      = 12'((data_base + rand_below(ls_words)) * 4);
          image[i] = itype(imm, 5'd0, 3'b010, rd, 7'b0000011);
        end
        default: begin
          imm      = 12'((data_base + rand_below(ls_words)) * 4);
          image[i] = stype(imm, rb, 5'd0);
        end
      endcase
      i++;
    end
    image[prog_words-1] = 32'h0000_0073;
    for (k = 0; k < data_words; k++) begin
      image[data_base + k] = $random(seed);
    end
  endtask

  task automatic load_program();
    for (int a = 0; a < data_base + data_words; a++) begin
      @(negedge clk);
      load_valid = 1'b1;
      load_addr  = core_cfg_pkg::mem_addr_t'(a);
      load_data  = image[a];
    end
    @(negedge clk);
    load_valid = 1'b0;
  endtask

  task automatic wait_for_halt(int prog);
    int n;
    n = 0;
    while (halt !== 1'b1 && n < halt_timeout) begin
      @(negedge clk);
      n++;
    end
    if (halt !== 1'b1) begin
      $display("timeout: program %0d did not halt in %0d cycles", prog, halt_timeout);
      tb_errors++;
    end
  endtask

  initial begin
    rst        = 1'b1;
    load_valid = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    for (int p = 0; p < num_programs; p++) begin
      seed = base_seed + p;
      build_program();
      @(negedge clk);
      rst = 1'b1;
      load_program();
      repeat (reset_cycles) @(negedge clk);
      rst = 1'b0;
      wait_for_halt(p);
      // quiet window after halt
      repeat (quiet_cycles) @(negedge clk);
    end
    $display("errors: %0d (checker %0d, testbench %0d)",
             checker_errors + tb_errors, checker_errors, tb_errors);
    if (checker_errors + tb_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: list.f
common/rv_isa_pkg.sv
common/core_cfg_pkg.sv
rtl/core/rv_decoder.sv
rtl/core/rv_alu.sv
rtl/core/rv_regfile.sv
rtl/core/rv_core.sv
rtl/rv_mem.sv
rtl/rv_top.sv
dv/rv_checker.sv
dv/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed!
VFLAGS    ?= --binary -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
